// File: lstm_gate_top.f
+incdir+hdl
hdl/lstm_num_pkg.sv
hdl/lstm_mem_pkg.sv
hdl/weight_ram.sv
hdl/weight_arbiter.sv
hdl/row_fetch.sv
hdl/vecmat_dot.sv
hdl/gate_sum.sv
hdl/lstm_gate_top.sv
tests/lstm_gate_properties.sv
tests/lstm_gate_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the LSTM gate testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module lstm_gate_tb \
	-f lstm_gate_top.f \
	-o sim_lstm_gate
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_lstm_gate 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "TESTS PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tests/lstm_gate_tb.sv
`timescale 1ns/1ps

`include "lstm_cfg.svh"

module lstm_gate_tb
	import lstm_num_pkg::*, lstm_mem_pkg::*;
();

	localparam int LOAD_CYCLES = 16 + 8 + 2 * (`MEM_DEPTH + 1) + `ROWS + 1 + 3;
	localparam int TIMEOUT_CYCLES = 4 * (`ROWS * 8 + 50) + LOAD_CYCLES;
	localparam int WORD_HI = (1 << (`DATA_WIDTH - 1)) - 1;
	localparam int WORD_LO = -(1 << (`DATA_WIDTH - 1));

	logic clk;
	logic reset, start, wr_en;
	waddr_t wr_addr;
	vec_t wr_data, x_vec, h_vec;
	logic busy, out_valid, done;
	row_idx_t out_row;
	word_t out_data;

	vec_t w_model [`MEM_DEPTH];
	vec_t x_model, h_model;
	word_t exp_data [`ROWS];
	logic [31:0] lcg_state;
	logic [`ROWS-1:0] seen = '0;
	int row_count = 0;
	int total_results = 0;
	int total_dones = 0;
	int cycle_count = 0;

	lstm_gate_top i_lstm_gate_top (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ten bits give about +-2.0 in Q8.8
	function automatic word_t small_word(logic [31:0] r);
		logic signed [9:0] v;
		v = r[25:16];
		return word_t'(v);
	endfunction

	function automatic int lane_dot(vec_t v, vec_t w);
		int sum;
		int p;
		sum = 0;
		for (int i = 0; i < `LANES; i++) begin
			p = int'(word_t'(v[i])) * int'(word_t'(w[i]));
			sum += int'(word_t'(p >>> `FRAC_BITS)); // scaled lane truncated to a word
		end
		return sum;
	endfunction

	function automatic word_t clamp_word(int s);
		if (s > WORD_HI)
			return word_t'(WORD_HI);
		if (s < WORD_LO)
			return word_t'(WORD_LO);
		return word_t'(s);
	endfunction

	task automatic fail_check(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input int got, input int want);
		$display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, want);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic write_row(input int addr, input vec_t row);
		@(posedge clk);
		wr_en   <= 1'b1;
		wr_addr <= waddr_t'(addr);
		wr_data <= row;
		w_model[addr] = row;
	endtask

	task automatic load_random_rows(input int base, input int count);
		vec_t row;
		for (int r = base; r < base + count; r++) begin
			for (int i = 0; i < `LANES; i++) begin
				lcg_state = lcg_next(lcg_state);
				row[i] = small_word(lcg_state);
			end
			write_row(r, row);
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic random_vectors();
		for (int i = 0; i < `LANES; i++) begin
			lcg_state = lcg_next(lcg_state);
			x_model[i] = small_word(lcg_state);
			lcg_state = lcg_next(lcg_state);
			h_model[i] = small_word(lcg_state);
		end
		@(posedge clk);
		x_vec <= x_model;
		h_vec <= h_model;
	endtask

	// 8.0 vectors against rows of +-8.0 down to +-4.25 overflow the word range
	task automatic load_saturating_rows();
		int mag;
		vec_t row;
		for (int r = 0; r < `MEM_DEPTH; r++) begin
			mag = 'h800 - (r % `ROWS) * 'h40;
			for (int i = 0; i < `LANES; i++)
				row[i] = word_t'(r[0] ? -mag : mag); // odd rows go negative
			write_row(r, row);
		end
		x_model = {`LANES{word_t'('h800)}};
		h_model = {`LANES{word_t'('h800)}};
		@(posedge clk);
		wr_en <= 1'b0;
		x_vec <= x_model;
		h_vec <= h_model;
	endtask

	task automatic run_rows(input bit extra_start);
		int results_before;
		int dones_before;
		int pulses;
		for (int r = 0; r < `ROWS; r++)
			exp_data[r] = clamp_word(lane_dot(x_model, w_model[r])
				+ lane_dot(h_model, w_model[`ROWS + r]));
		results_before = total_results;
		dones_before = total_dones;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (extra_start) begin
			// after the fetchers finish but before done
			pulses = 0;
			while (pulses < `ROWS - 2) begin
				@(posedge clk);
				if (out_valid)
					pulses++;
			end
			assert (busy) else fail_check("DUT not busy when the second start was sent");
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		while (!done)
			@(posedge clk);
		@(posedge clk);
		assert (total_dones - dones_before == 1)
			else report_mismatch("done pulses", total_dones - dones_before, 1);
		assert (total_results - results_before == `ROWS)
			else report_mismatch("out_valid pulses", total_results - results_before, `ROWS);
		assert (!busy) else fail_check("busy still high the cycle after done");
	endtask

	// rows finish in fetch order with one result each
	always @(posedge clk) begin
		if (reset && out_valid) begin
			assert (out_row == row_idx_t'(row_count))
				else report_mismatch("out_row", int'(out_row), row_count);
			assert (!seen[out_row]) else fail_check("a row was reported twice in one run");
			assert (out_data == exp_data[out_row])
				else report_mismatch("out_data", int'(out_data), int'(exp_data[out_row]));
			seen[out_row] = 1'b1;
			row_count++;
			total_results++;
		end
		if (reset && done) begin
			assert (row_count == `ROWS) else fail_check("done came before all rows were reported");
			row_count = 0;
			seen = '0;
			total_dones++;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("ERROR: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	initial begin
		clk = 1'b0;
		reset <= 1'b0;
		start <= 1'b0;
		wr_en <= 1'b0;
		wr_addr <= '0;
		wr_data <= '0;
		x_vec <= '0;
		h_vec <= '0;
		lcg_state = 32'h22cf;
		repeat (16) @(posedge clk);
		reset <= 1'b1;
		repeat (8) begin
			@(posedge clk);
			assert (!busy && !out_valid && !done)
				else fail_check("busy, out_valid or done high before the first start");
		end
		load_random_rows(0, `MEM_DEPTH);
		random_vectors();
		run_rows(1'b0);
		random_vectors();
		run_rows(1'b1); // start again while busy
		load_random_rows(`ROWS, `ROWS); // new h bank only
		run_rows(1'b0);
		load_saturating_rows();
		run_rows(1'b0);
		@(posedge clk);
		if (total_results == 4 * `ROWS && total_dones == 4) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("ERROR: result or done count wrong at the end of the runs");
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

endmodule

// File: tests/lstm_gate_properties.sv
`timescale 1ns/1ps

module lstm_gate_properties (
	input logic clk,
	input logic reset,
	input logic req_x,
	input logic req_h,
	input logic grant_x,
	input logic grant_h,
	input logic busy,
	input logic out_valid,
	input logic done,
	input logic wr_en
);

	a_one_grant: assert property (@(posedge clk) disable iff (!reset)
		!(grant_x && grant_h))
		else $error("grant_x and grant_h high in the same cycle");

	a_hold_req_x: assert property (@(posedge clk) disable iff (!reset)
		req_x && !grant_x |=> req_x)
		else $error("req_x dropped before its grant");

	a_hold_req_h: assert property (@(posedge clk) disable iff (!reset)
		req_h && !grant_h |=> req_h)
		else $error("req_h dropped before its grant");

	// results only inside a run
	a_out_busy: assert property (@(posedge clk) disable iff (!reset)
		out_valid || done |-> busy)
		else $error("out_valid or done while not busy");

	a_no_write: assert property (@(posedge clk) disable iff (!reset)
		wr_en |-> !busy)
		else $error("weight write while busy");

endmodule

bind lstm_gate_top lstm_gate_properties i_lstm_gate_properties (
	.clk(clk), .reset(reset), .req_x(req_x), .req_h(req_h),
	.grant_x(grant_x), .grant_h(grant_h), .busy(busy),
	.out_valid(out_valid), .done(done), .wr_en(wr_en)
);

// File: hdl/lstm_gate_top.sv
`timescale 1ns/1ps

`include "lstm_cfg.svh"

module lstm_gate_top
	import lstm_num_pkg::*, lstm_mem_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	input  logic     wr_en,
	input  waddr_t   wr_addr,
	input  vec_t     wr_data,
	input  vec_t     x_vec,
	input  vec_t     h_vec,
	output logic     busy,
	output logic     out_valid,
	output row_idx_t out_row,
	output word_t    out_data,
	output logic     done
);

	logic     fetch_start;
	logic     req_x, req_h;
	logic     grant_x, grant_h;
	logic     ready_x, ready_h;
	waddr_t   addr_x, addr_h;
	logic     mem_en;
	waddr_t   mem_addr;
	vec_t     mem_row;
	logic     row_valid_x, row_valid_h;
	row_idx_t row_tag_x, row_tag_h;
	logic     dot_valid_x, dot_valid_h;
	row_idx_t dot_tag_x, dot_tag_h;
	acc_t     dot_x, dot_h;

	assign fetch_start = start && !busy; // no restart mid-run

	weight_ram i_weight_ram (
		.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_en(mem_en), .rd_addr(mem_addr), .rd_data(mem_row)
	);

	weight_arbiter i_weight_arbiter (
		.clk(clk), .reset(reset), .req_x(req_x), .req_h(req_h),
		.addr_x(addr_x), .addr_h(addr_h), .grant_x(grant_x), .grant_h(grant_h),
		.mem_en(mem_en), .mem_addr(mem_addr),
		.data_ready_x(ready_x), .data_ready_h(ready_h)
	);

	row_fetch #(.BASE(0)) i_fetch_x (
		.clk(clk), .reset(reset), .start(fetch_start), .grant(grant_x),
		.data_ready(ready_x), .req(req_x), .addr(addr_x),
		.row_valid(row_valid_x), .row_tag(row_tag_x)
	);

	row_fetch #(.BASE(`ROWS)) i_fetch_h (
		.clk(clk), .reset(reset), .start(fetch_start), .grant(grant_h),
		.data_ready(ready_h), .req(req_h), .addr(addr_h),
		.row_valid(row_valid_h), .row_tag(row_tag_h)
	);

	vecmat_dot i_dot_x (
		.clk(clk), .reset(reset), .row_valid(row_valid_x), .row_tag(row_tag_x),
		.vector(x_vec), .weights(mem_row),
		.dot_valid(dot_valid_x), .dot_tag(dot_tag_x), .dot_value(dot_x)
	);

	vecmat_dot i_dot_h (
		.clk(clk), .reset(reset), .row_valid(row_valid_h), .row_tag(row_tag_h),
		.vector(h_vec), .weights(mem_row),
		.dot_valid(dot_valid_h), .dot_tag(dot_tag_h), .dot_value(dot_h)
	);

	gate_sum i_gate_sum (
		.clk(clk), .reset(reset), .start(start),
		.x_valid(dot_valid_x), .x_tag(dot_tag_x), .x_value(dot_x),
		.h_valid(dot_valid_h), .h_tag(dot_tag_h), .h_value(dot_h),
		.busy(busy), .out_valid(out_valid), .out_row(out_row),
		.out_data(out_data), .done(done)
	);

endmodule

// File: hdl/gate_sum.sv
`timescale 1ns/1ps

`include "lstm_cfg.svh"

module gate_sum
	import lstm_num_pkg::*, lstm_mem_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	input  logic     x_valid,
	input  row_idx_t x_tag,
	input  acc_t     x_value,
	input  logic     h_valid,
	input  row_idx_t h_tag,
	input  acc_t     h_value,
	output logic     busy,
	output logic     out_valid,
	output row_idx_t out_row,
	output word_t    out_data,
	output logic     done
);

	acc_t            x_slot [`ROWS];
	acc_t            h_slot [`ROWS];
	logic [`ROWS-1:0] x_have;
	logic [`ROWS-1:0] h_have;
	logic            hit;
	row_idx_t        hit_row;
	row_idx_t        count;

	// lowest row with both halves present
	always_comb begin
		hit     = 1'b0;
		hit_row = '0;
		for (int r = `ROWS - 1; r >= 0; r--) begin
			if (x_have[r] && h_have[r]) begin
				hit     = 1'b1;
				hit_row = row_idx_t'(r);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (x_valid)
			x_slot[x_tag] <= x_value;
		if (h_valid)
			h_slot[h_tag] <= h_value;
		if (hit) begin
			out_row  <= hit_row;
			out_data <= sat_word(x_slot[hit_row] + h_slot[hit_row]);
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			x_have    <= '0;
			h_have    <= '0;
			busy      <= 1'b0;
			out_valid <= 1'b0;
			done      <= 1'b0;
			count     <= '0;
		end else begin
			if (hit) begin
				x_have[hit_row] <= 1'b0; // slot free again
				h_have[hit_row] <= 1'b0;
			end
			if (x_valid)
				x_have[x_tag] <= 1'b1;
			if (h_valid)
				h_have[h_tag] <= 1'b1;
			out_valid <= hit;
			done      <= out_valid && (count == row_idx_t'(`ROWS - 1));
			if (out_valid)
				count <= count + 1'b1;
			if (start && !busy) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (done) begin
				busy <= 1'b0; // drops the cycle after done
			end
		end
	end

endmodule

// File: hdl/vecmat_dot.sv
`timescale 1ns/1ps

`include "lstm_cfg.svh"

module vecmat_dot
	import lstm_num_pkg::*, lstm_mem_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     row_valid,
	input  row_idx_t row_tag,
	input  vec_t     vector,
	input  vec_t     weights,
	output logic     dot_valid,
	output row_idx_t dot_tag,
	output acc_t     dot_value
);

	// leaf count of the adder tree, padded to a power of two
	localparam int TREE_W = 1 << $clog2(`LANES);

	vec_t     vec_r;
	vec_t     wt_r;
	vec_t     scaled;
	vec_t     scaled_r;
	acc_t     tree [1:2*TREE_W-1];
	acc_t     sum_r;
	logic     v1, v2, v3;
	row_idx_t tag1, tag2, tag3;

	for (genvar i = 0; i < `LANES; i++) begin : g_lane
		prod_t prod;

		assign prod      = prod_t'(word_t'(vec_r[i])) * prod_t'(word_t'(wt_r[i]));
		assign scaled[i] = word_t'(prod >>> `FRAC_BITS); // back to Q8.8
	end

	for (genvar i = 0; i < TREE_W; i++) begin : g_leaf
		if (i < `LANES) begin : g_used
			assign tree[TREE_W + i] = acc_t'(word_t'(scaled_r[i]));
		end else begin : g_pad
			assign tree[TREE_W + i] = '0;
		end
	end

	for (genvar n = 1; n < TREE_W; n++) begin : g_node
		assign tree[n] = tree[2*n] + tree[2*n + 1];
	end

	// data path, three stages
	always_ff @(posedge clk) begin
		vec_r    <= vector;
		wt_r     <= weights;
		scaled_r <= scaled;
		sum_r    <= tree[1];
		tag1     <= row_tag;
		tag2     <= tag1;
		tag3     <= tag2;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
		end else begin
			v1 <= row_valid;
			v2 <= v1;
			v3 <= v2;
		end
	end

	assign dot_valid = v3;
	assign dot_tag   = tag3;
	assign dot_value = sum_r;

endmodule

// File: hdl/row_fetch.sv
`timescale 1ns/1ps

`include "lstm_cfg.svh"

module row_fetch
	import lstm_mem_pkg::*;
#(
	parameter int BASE = 0
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	input  logic     grant,
	input  logic     data_ready,
	output logic     req,
	output waddr_t   addr,
	output logic     row_valid,
	output row_idx_t row_tag
);

	logic     active;
	row_idx_t row;

	// tags of granted rows waiting for their data
	row_idx_t tag_q [2];
	logic     wr_ptr;
	logic     rd_ptr;

	assign req  = active;
	assign addr = waddr_t'(BASE) + waddr_t'(row);

	always_ff @(posedge clk) begin
		if (!reset) begin
			active <= 1'b0;
			row    <= '0;
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
		end else begin
			if (!active && start) begin
				active <= 1'b1;
				row    <= '0;
			end else if (grant) begin
				if (row == row_idx_t'(`ROWS - 1))
					active <= 1'b0; // last row of the bank
				row <= row + 1'b1;
			end
			if (grant)
				wr_ptr <= ~wr_ptr;
			if (data_ready)
				rd_ptr <= ~rd_ptr;
		end
	end

	always_ff @(posedge clk) begin
		if (grant)
			tag_q[wr_ptr] <= row;
	end

	assign row_valid = data_ready;
	assign row_tag   = tag_q[rd_ptr];

endmodule

// File: hdl/weight_arbiter.sv
`timescale 1ns/1ps

module weight_arbiter
	import lstm_mem_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   req_x,
	input  logic   req_h,
	input  waddr_t addr_x,
	input  waddr_t addr_h,
	output logic   grant_x,
	output logic   grant_h,
	output logic   mem_en,
	output waddr_t mem_addr,
	output logic   data_ready_x,
	output logic   data_ready_h
);

	req_id_t last_id;
	logic    pick_h;

	always_comb begin
		if (req_x && req_h)
			pick_h = (last_id == REQ_X); // alternate on contention
		else
			pick_h = req_h;
	end

	assign grant_h  = req_h && pick_h;
	assign grant_x  = req_x && !pick_h;
	assign mem_en   = grant_x || grant_h;
	assign mem_addr = pick_h ? addr_h : addr_x;

	always_ff @(posedge clk) begin
		if (!reset) begin
			last_id      <= REQ_H; // x wins the first tie
			data_ready_x <= 1'b0;
			data_ready_h <= 1'b0;
		end else begin
			if (mem_en)
				last_id <= pick_h ? REQ_H : REQ_X;
			data_ready_x <= mem_en && !pick_h; // row lands next cycle
			data_ready_h <= mem_en && pick_h;
		end
	end

endmodule

// File: hdl/weight_ram.sv
`timescale 1ns/1ps

`include "lstm_cfg.svh"

module weight_ram
	import lstm_num_pkg::*, lstm_mem_pkg::*;
(
	input  logic   clk,
	input  logic   wr_en,
	input  waddr_t wr_addr,
	input  vec_t   wr_data,
	input  logic   rd_en,
	input  waddr_t rd_addr,
	output vec_t   rd_data
);

	vec_t mem [`MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data; // loaded only while idle
		end
	end

	// one cycle read latency
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: hdl/lstm_mem_pkg.sv
package lstm_mem_pkg;

`include "lstm_cfg.svh"

	// row address into the shared weight memory
	typedef logic [$clog2(`MEM_DEPTH)-1:0] waddr_t;

	// row number inside one bank
	typedef logic [$clog2(`ROWS)-1:0] row_idx_t;

	typedef logic req_id_t;

	localparam req_id_t REQ_X = 1'b0;
	localparam req_id_t REQ_H = 1'b1;

endpackage

// File: hdl/lstm_num_pkg.sv
package lstm_num_pkg;

`include "lstm_cfg.svh"

	typedef logic signed [`DATA_WIDTH-1:0] word_t;
	typedef logic signed [2*`DATA_WIDTH-1:0] prod_t;
	typedef logic signed [`ACC_WIDTH-1:0] acc_t;
	typedef word_t [`LANES-1:0] vec_t;

	localparam word_t WORD_MAX = {1'b0, {(`DATA_WIDTH-1){1'b1}}};
	localparam word_t WORD_MIN = {1'b1, {(`DATA_WIDTH-1){1'b0}}};

	// clamp an accumulator into word range
	function automatic word_t sat_word(acc_t a);
		if (a > acc_t'(WORD_MAX))
			return WORD_MAX;
		if (a < acc_t'(WORD_MIN))
			return WORD_MIN;
		return word_t'(a);
	endfunction

endpackage

// File: hdl/lstm_cfg.svh
`ifndef LSTM_CFG_SVH
`define LSTM_CFG_SVH

// vector elements and multipliers per row
`define LANES 8
// output rows per weight matrix
`define ROWS 16

// Q8.8 words
`define DATA_WIDTH 16
`define FRAC_BITS 8
`define ACC_WIDTH (`DATA_WIDTH + 8)

// x bank then h bank
`define MEM_DEPTH (2 * `ROWS)

`endif
